/* design/icachePkg.sv */
// icache package: cache geometry plus the fetch address, request, fill and response types
`default_nettype none

package icachePkg;

    // fetch addresses count 32-bit instruction words
    localparam int addrWidth = 16;
    localparam int wordWidth = 32;
    localparam int blockWords = 4;
    localparam int numLines = 16;
    localparam int blockWidth = blockWords * wordWidth;

    // derived field widths
    localparam int offsetWidth = $clog2(blockWords);
    localparam int indexWidth = $clog2(numLines);
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
    localparam int blockAddrWidth = addrWidth - offsetWidth;

    // array view of a fetch address
    typedef struct packed {
        logic [tagWidth-1:0]    tag;
        logic [indexWidth-1:0]  index;
        logic [offsetWidth-1:0] word;
    } fetchAddrFields_t;

    // pipeline and memory use raw, the array uses fields
    typedef union packed {
        logic [addrWidth-1:0] raw;
        fetchAddrFields_t     fields;
    } fetchAddr_u;

    // request waiting for a lookup
    typedef struct packed {
        logic       valid;
        fetchAddr_u addr;
    } fetchReq_t;

    // block coming back from memory, valid is a one-cycle strobe
    typedef struct packed {
        logic                  valid;
        logic [blockWidth-1:0] block;
    } memFill_t;

    // word handed back to the pipeline
    typedef struct packed {
        logic                 valid;
        logic [wordWidth-1:0] word;
    } fetchRsp_t;

endpackage

`default_nettype wire

/* design/fetchRequestPort.sv */
// fetch request port: captures a pipeline fetch strobe and address into the pending request
`default_nettype none

module fetchRequestPort
    import icachePkg::*;
(
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 fetchValid,
    input  wire logic [addrWidth-1:0] fetchAddr,
    input  wire logic                 retire,
    output fetchReq_t                 pendingReq
);

    logic       pendingValid;
    fetchAddr_u pendingAddr;
    logic       accept;

    // only one request in flight, a strobe during a pending one is dropped
    assign accept = fetchValid && !pendingValid;

    // valid bit is control state
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pendingValid <= 1'b0;
        end else if (accept) begin
            pendingValid <= 1'b1;
        end else if (retire) begin
            // response taken this edge
            pendingValid <= 1'b0;
        end
    end

    // address is payload
    always_ff @(posedge clock) begin
        if (accept) begin
            pendingAddr.raw <= fetchAddr;
        end
    end

    // the union presents the tag, index and word fields downstream
    always_comb begin
        pendingReq.valid = pendingValid;
        pendingReq.addr  = pendingAddr;
    end

endmodule

`default_nettype wire

/* design/icacheArray.sv */
// icache array: direct-mapped tag, valid and block storage with hit detection and line fill
`default_nettype none

module icacheArray
    import icachePkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire fetchReq_t             pendingReq,
    input  wire logic                  fillWen,
    input  wire logic [blockWidth-1:0] fillBlock,
    output logic                       hit,
    output logic      [blockWidth-1:0] lineBlock
);

    logic [tagWidth-1:0]   tagMem   [numLines];
    logic [blockWidth-1:0] blockMem [numLines];
    logic [numLines-1:0]   lineValid;

    logic [indexWidth-1:0] lineIndex;
    logic [tagWidth-1:0]   reqTag;
    logic [tagWidth-1:0]   lineTag;
    logic                  tagMatch;

    // decode through the field view
    assign lineIndex = pendingReq.addr.fields.index;
    assign reqTag    = pendingReq.addr.fields.tag;

    // valid bits clear on reset, so every line starts empty
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            lineValid <= '0;
        end else if (fillWen) begin
            lineValid[lineIndex] <= 1'b1;
        end
    end

    // tag and data storage, written only by a fill
    always_ff @(posedge clock) begin
        if (fillWen) begin
            tagMem[lineIndex]   <= reqTag;
            blockMem[lineIndex] <= fillBlock;
        end
    end

    // combinational read of the indexed line
    assign lineTag   = tagMem[lineIndex];
    assign lineBlock = blockMem[lineIndex];
    assign tagMatch  = (lineTag == reqTag);

    // a line only counts with a live request behind it
    assign hit = pendingReq.valid && lineValid[lineIndex] && tagMatch;

endmodule

`default_nettype wire

/* design/icacheController.sv */
// icache controller: miss FSM with idle, memory read and fill, driving busy and the memory read
`default_nettype none

module icacheController
    import icachePkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire fetchReq_t                 pendingReq,
    input  wire logic                      hit,
    input  wire memFill_t                  memFill,
    output logic                           busy,
    output logic                           memRen,
    output logic      [blockAddrWidth-1:0] memBlockAddr,
    output logic                           fillWen,
    output logic      [blockWidth-1:0]     fillBlock,
    output logic                           retire,
    output logic                           rspTake
);

    localparam logic [1:0] idleState    = 2'b00;
    localparam logic [1:0] memReadState = 2'b01;
    localparam logic [1:0] fillState    = 2'b10;

    logic [1:0]            state;
    logic [1:0]            nextState;
    logic [blockWidth-1:0] fillBlockReg;
    logic                  pendingHit;
    logic                  pendingMiss;

    assign pendingHit  = pendingReq.valid && hit;
    assign pendingMiss = pendingReq.valid && !hit;

    // state register
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= idleState;
        end else begin
            state <= nextState;
        end
    end

    // next state
    always_comb begin
        nextState = state;
        case (state)
            idleState: begin
                if (pendingMiss) begin
                    nextState = memReadState;
                end
            end
            memReadState: begin
                // wait as long as memory needs
                if (memFill.valid) begin
                    nextState = fillState;
                end
            end
            fillState: begin
                // back to idle, the lookup replays and hits
                nextState = idleState;
            end
            default: begin
                nextState = idleState;
            end
        endcase
    end

    // returned block, held for the fill cycle
    always_ff @(posedge clock) begin
        if (state == memReadState && memFill.valid) begin
            fillBlockReg <= memFill.block;
        end
    end

    // decoded outputs
    always_comb begin
        memRen  = 1'b0;
        fillWen = 1'b0;
        retire  = 1'b0;
        rspTake = 1'b0;
        case (state)
            idleState: begin
                retire  = pendingHit;
                rspTake = pendingHit;
            end
            memReadState: begin
                memRen = 1'b1;
            end
            fillState: begin
                fillWen = 1'b1;
            end
            default: begin
                memRen = 1'b0;
            end
        endcase
    end

    // pipeline holds off while anything is in flight
    assign busy = pendingReq.valid || (state != idleState);

    // tag and index, steady for the whole read since the request is held
    assign memBlockAddr = {pendingReq.addr.fields.tag, pendingReq.addr.fields.index};
    assign fillBlock    = fillBlockReg;

endmodule

`default_nettype wire

/* design/fetchResponsePort.sv */
// fetch response port: picks the addressed word from the line and registers the response
`default_nettype none

module fetchResponsePort
    import icachePkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  rspTake,
    input  wire fetchReq_t             pendingReq,
    input  wire logic [blockWidth-1:0] lineBlock,
    output fetchRsp_t                  fetchRsp
);

    logic [offsetWidth-1:0] wordSel;
    logic [wordWidth-1:0]   selWord;
    logic                   rspValid;
    logic [wordWidth-1:0]   rspWord;

    // word 0 sits in the low bits of the block
    assign wordSel = pendingReq.addr.fields.word;
    assign selWord = lineBlock[wordSel*wordWidth +: wordWidth];

    // one-cycle strobe
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= rspTake;
        end
    end

    always_ff @(posedge clock) begin
        if (rspTake) begin
            rspWord <= selWord;
        end
    end

    always_comb begin
        fetchRsp.valid = rspValid;
        fetchRsp.word  = rspWord;
    end

endmodule

`default_nettype wire

/* design/icacheTop.sv */
// icache top: joins request capture, controller, array and response port to pipeline and memory
`default_nettype none

module icacheTop
    import icachePkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      fetchValid,
    input  wire logic [addrWidth-1:0]      fetchAddr,
    output logic                           busy,
    output fetchRsp_t                      fetchRsp,
    output logic                           memRen,
    output logic      [blockAddrWidth-1:0] memBlockAddr,
    input  wire memFill_t                  memFill
);

    fetchReq_t             pendingReq;
    logic                  hit;
    logic [blockWidth-1:0] lineBlock;
    logic                  fillWen;
    logic [blockWidth-1:0] fillBlock;
    logic                  retire;
    logic                  rspTake;

    // input side
    fetchRequestPort requestPort_i (
        .clock      (clock),
        .reset      (reset),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .retire     (retire),
        .pendingReq (pendingReq)
    );

    icacheArray array_i (
        .clock      (clock),
        .reset      (reset),
        .pendingReq (pendingReq),
        .fillWen    (fillWen),
        .fillBlock  (fillBlock),
        .hit        (hit),
        .lineBlock  (lineBlock)
    );

    icacheController controller_i (
        .clock        (clock),
        .reset        (reset),
        .pendingReq   (pendingReq),
        .hit          (hit),
        .memFill      (memFill),
        .busy         (busy),
        .memRen       (memRen),
        .memBlockAddr (memBlockAddr),
        .fillWen      (fillWen),
        .fillBlock    (fillBlock),
        .retire       (retire),
        .rspTake      (rspTake)
    );

    // output side
    fetchResponsePort responsePort_i (
        .clock      (clock),
        .reset      (reset),
        .rspTake    (rspTake),
        .pendingReq (pendingReq),
        .lineBlock  (lineBlock),
        .fetchRsp   (fetchRsp)
    );

endmodule

`default_nettype wire

/* dv/clockGen.sv */
// testbench clock and reset: 4 ns clock, active-low reset held for 8 cycles
`default_nettype none

module clockGen (
    output logic clock,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 8;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // release on a rising edge, like any other driven input
    initial begin
        reset = 1'b0;
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/icache_props.sv */
// icache controller properties for the memory read hold, the fill pulse and the replay hit
`default_nettype none

module icacheProps
    import icachePkg::*;
(
    input wire logic                      clock,
    input wire logic                      reset,
    input wire logic                      memRen,
    input wire logic [blockAddrWidth-1:0] memBlockAddr,
    input wire memFill_t                  memFill,
    input wire logic                      fillWen,
    input wire logic                      busy,
    input wire logic                      rspTake
);

    timeunit 1ns;
    timeprecision 100ps;

    // read request and its address stay put until memory answers
    memReadHeld: assert property (
        @(posedge clock) disable iff (!reset)
        memRen && !memFill.valid |=> memRen && $stable(memBlockAddr)
    ) else $error("memRen dropped or memBlockAddr moved before the memory strobe");

    // the fill write is a single-cycle pulse
    fillPulse: assert property (
        @(posedge clock) disable iff (!reset)
        fillWen |=> !fillWen
    ) else $error("fillWen stayed high for more than one cycle");

    // pipeline stays held off until the replayed lookup hits
    replayHit: assert property (
        @(posedge clock) disable iff (!reset)
        fillWen |=> rspTake && busy
    ) else $error("the lookup after a fill did not hit while busy was held");

endmodule

bind icacheController icacheProps props_i (
    .clock        (clock),
    .reset        (reset),
    .memRen       (memRen),
    .memBlockAddr (memBlockAddr),
    .memFill      (memFill),
    .fillWen      (fillWen),
    .busy         (busy),
    .rspTake      (rspTake)
);

`default_nettype wire

/* dv/icacheTb.sv */
// icache testbench with memory model, shadow cache, LCG fetch stream and response checks
`default_nettype none

module icacheTb
    import icachePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int waitLimit = 200;
    localparam int idleLimit = 100000;
    localparam int hitLatency = 2;
    localparam int randomFetches = 400;

    typedef struct packed {
        logic                 miss;
        logic [wordWidth-1:0] word;
        logic [31:0]          driveCycle;
    } expectEntry_t;

    logic                      clock;
    logic                      reset;
    logic                      fetchValid;
    logic [addrWidth-1:0]      fetchAddr;
    logic                      busy;
    fetchRsp_t                 fetchRsp;
    logic                      memRen;
    logic [blockAddrWidth-1:0] memBlockAddr;
    memFill_t                  memFill;

    // shadow copy of the tag and valid state
    logic [tagWidth-1:0] shadowTag [numLines];
    logic [numLines-1:0] shadowValid;

    expectEntry_t         expectQ [$];
    int                   cycleCount = 0;
    int                   memReqCount = 0;
    int                   missCount = 0;
    int                   fetchCount = 0;
    int                   rspCount = 0;
    int                   reqAtLastRsp = 0;
    int                   errorCount = 0;
    logic [addrWidth-1:0] lastFetchAddr;
    logic [31:0]          stimLcg = 32'd7;
    logic [31:0]          memLcg = 32'd7;

    clockGen clockGen_i (
        .clock (clock),
        .reset (reset)
    );

    icacheTop dut_i (
        .clock        (clock),
        .reset        (reset),
        .fetchValid   (fetchValid),
        .fetchAddr    (fetchAddr),
        .busy         (busy),
        .fetchRsp     (fetchRsp),
        .memRen       (memRen),
        .memBlockAddr (memBlockAddr),
        .memFill      (memFill)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // fixed hash of the word address
    function automatic logic [wordWidth-1:0] memWord(input logic [addrWidth-1:0] addr);
        logic [31:0] mix;
        mix = {addr, addr ^ 16'hC35A};
        mix = mix * 32'h9E3779B1;
        return mix ^ (mix >> 15);
    endfunction

    // word 0 of a block goes in the low bits
    function automatic logic [blockWidth-1:0] memBlock(input logic [blockAddrWidth-1:0] blockAddr);
        logic [blockWidth-1:0] block;
        for (int i = 0; i < blockWords; i++) begin
            block[i*wordWidth +: wordWidth] = memWord({blockAddr, offsetWidth'(i)});
        end
        return block;
    endfunction

    // expected outcome of a fetch given the current shadow state
    function automatic expectEntry_t refLookup(input logic [addrWidth-1:0] addr);
        expectEntry_t entry;
        fetchAddr_u   split;
        split.raw = addr;
        entry.miss = !(shadowValid[split.fields.index]
                       && shadowTag[split.fields.index] == split.fields.tag);
        entry.word = memWord(addr);
        entry.driveCycle = '0;
        return entry;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic issueFetch(input logic [addrWidth-1:0] addr);
        expectEntry_t entry;
        fetchAddr_u   split;
        int           waited;
        waited = 0;
        split.raw = addr;
        @(negedge clock);
        while (busy) begin
            @(negedge clock);
            waited++;
            if (waited > waitLimit) begin
                abortRun("busy stayed high, the fetch could not be issued");
            end
        end
        entry = refLookup(addr);
        // strobe goes out on the coming rising edge
        entry.driveCycle = cycleCount + 1;
        shadowValid[split.fields.index] = 1'b1;
        shadowTag[split.fields.index] = split.fields.tag;
        if (entry.miss) begin
            missCount++;
        end
        fetchCount++;
        lastFetchAddr = addr;
        expectQ.push_back(entry);
        @(posedge clock);
        fetchValid <= 1'b1;
        fetchAddr  <= addr;
        @(posedge clock);
        fetchValid <= 1'b0;
    endtask

    task automatic drainResponses();
        int waited;
        waited = 0;
        while (expectQ.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > waitLimit) begin
                abortRun("a fetch never got its response");
            end
        end
    endtask

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // memory model answering each read after 1 to 8 cycles
    always begin : memoryModel
        int                        waited;
        int                        delay;
        logic [blockAddrWidth-1:0] reqBlockAddr;
        waited = 0;
        @(negedge clock);
        while (!(reset && memRen)) begin
            @(negedge clock);
            waited++;
            if (waited > idleLimit) begin
                abortRun("no memory read was requested for too long");
            end
        end
        memReqCount++;
        reqBlockAddr = memBlockAddr;
        checkValue("memBlockAddr", reqBlockAddr, lastFetchAddr[addrWidth-1:offsetWidth]);
        memLcg = lcgNext(memLcg);
        delay = 1 + memLcg[18:16];
        repeat (delay) @(posedge clock);
        memFill.block <= memBlock(reqBlockAddr);
        memFill.valid <= 1'b1;
        @(posedge clock);
        memFill.valid <= 1'b0;
    end

    // compare every response against the reference
    always @(negedge clock) begin : compareRsp
        expectEntry_t entry;
        if (reset && fetchRsp.valid) begin
            if (expectQ.size() == 0) begin
                abortRun("response strobe with no fetch outstanding");
            end else begin
                entry = expectQ.pop_front();
                checkValue("fetchRsp.word", fetchRsp.word, entry.word);
                checkValue("memory requests for this fetch", memReqCount - reqAtLastRsp,
                           entry.miss);
                if (!entry.miss) begin
                    checkValue("hit latency", cycleCount - entry.driveCycle, hitLatency);
                end
                reqAtLastRsp = memReqCount;
                rspCount++;
            end
        end
    end

    initial begin : mainSequence
        int waited;
        fetchValid = 1'b0;
        fetchAddr = '0;
        memFill = '0;
        shadowValid = '0;
        waited = 0;
        while (reset !== 1'b1) begin
            @(negedge clock);
            waited++;
            if (waited > waitLimit) begin
                abortRun("reset was never released");
            end
        end
        @(negedge clock);
        checkValue("busy", busy, 1'b0);
        checkValue("memRen", memRen, 1'b0);
        checkValue("fetchRsp.valid", fetchRsp.valid, 1'b0);

        // cold miss then every word of the resident block
        issueFetch(16'h0123);
        for (int w = 0; w < blockWords; w++) begin
            issueFetch(16'h0120 + 16'(w));
        end

        // same index with a different tag
        for (int n = 0; n < 3; n++) begin
            issueFetch(16'h0521);
            issueFetch(16'h0122);
        end

        // 128 words over 16 lines keeps a mix of hits and conflicts
        for (int n = 0; n < randomFetches; n++) begin
            stimLcg = lcgNext(stimLcg);
            issueFetch(16'h3000 | 16'(stimLcg[22:16]));
        end

        drainResponses();
        checkValue("total memory requests", memReqCount, missCount);
        checkValue("total responses", rspCount, fetchCount);

        if (errorCount == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* files.f */
design/icachePkg.sv
design/fetchRequestPort.sv
design/icacheArray.sv
design/icacheController.sv
design/fetchResponsePort.sv
design/icacheTop.sv
dv/clockGen.sv
dv/icache_props.sv
dv/icacheTb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - design/icachePkg.sv
  - design/fetchRequestPort.sv
  - design/icacheArray.sv
  - design/icacheController.sv
  - design/fetchResponsePort.sv
  - design/icacheTop.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/icache_props.sv
      - dv/icacheTb.sv
